// ==== project.f ====
+incdir+verif
source/rafiPkg.sv
source/bypassIf.sv
source/bypassLogic.sv
source/operandRegFile.sv
source/stallTimer.sv
source/pipelineController.sv
source/operandReadStage.sv
verif/operandReadStageTb.sv

// ==== source/bypassIf.sv ====
`timescale 1ns/1ps

interface bypassIf #(
    parameter int BypassDepth = 3
);
    import rafiPkg::*;

    // Write-back side, at most one result per cycle
    logic    writeEnable;
    regAddrT writeAddr;
    wordT    writeValue;

    // Two read ports
    regAddrT readAddr1;
    regAddrT readAddr2;
    wordT    readValue1;
    wordT    readValue2;
    logic    hit1;
    logic    hit2;

    // Supported depth range of the bypass pipeline
    if (BypassDepth < 1 || BypassDepth > 8) begin : gDepthCheck
        $error("bypassIf: BypassDepth %0d outside 1..8", BypassDepth);
    end

    modport Writer (
        output writeEnable, writeAddr, writeValue
    );

    modport Reader (
        output readAddr1, readAddr2,
        input  readValue1, readValue2, hit1, hit2
    );

    modport BypassLogic (
        input  writeEnable, writeAddr, writeValue, readAddr1, readAddr2,
        output readValue1, readValue2, hit1, hit2
    );

endinterface

// ==== source/bypassLogic.sv ====
`timescale 1ns/1ps

module bypassLogic #(
    parameter int BypassDepth = 3
) (
    input  logic         clk,
    input  logic         rstN,
    bypassIf.BypassLogic bus,
    input  logic         flush,
    input  logic         bypassStall
);
    import rafiPkg::*;

    // Entry 0 holds the youngest result
    logic [BypassDepth-1:0] entryValid;
    regAddrT                entryAddr [BypassDepth];
    wordT                   entryValue [BypassDepth];

    logic [BypassDepth-1:0] camHit1;
    logic [BypassDepth-1:0] camHit2;
    wordT                   camValue1;
    wordT                   camValue2;

    // Match vectors per read port
    always_comb begin
        for (int j = 0; j < BypassDepth; j++) begin
            camHit1[j] = entryValid[j] && (entryAddr[j] == bus.readAddr1);
            camHit2[j] = entryValid[j] && (entryAddr[j] == bus.readAddr2);
        end
    end

    // Oldest to youngest, so the lowest matching index is the last one written
    always_comb begin
        camValue1 = '0;
        camValue2 = '0;
        for (int j = BypassDepth - 1; j >= 0; j--) begin
            if (camHit1[j]) begin
                camValue1 = entryValue[j];
            end
            if (camHit2[j]) begin
                camValue2 = entryValue[j];
            end
        end
    end

    assign bus.hit1 = |camHit1;
    assign bus.hit2 = |camHit2;

    // x0 reports its hit but never forwards data
    assign bus.readValue1 = (bus.readAddr1 == '0) ? '0 : camValue1;
    assign bus.readValue2 = (bus.readAddr2 == '0) ? '0 : camValue2;

    // Valid bits, cleared by flush, frozen by stall
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            entryValid <= '0;
        end else if (flush) begin
            entryValid <= '0;
        end else if (!bypassStall) begin
            entryValid[0] <= bus.writeEnable;
            for (int i = 1; i < BypassDepth; i++) begin
                entryValid[i] <= entryValid[i-1];
            end
        end
    end

    // Address and data shift alongside the valid bits
    always_ff @(posedge clk) begin
        if (!bypassStall) begin
            entryAddr[0] <= bus.writeAddr;
            entryValue[0] <= bus.writeValue;
            for (int i = 1; i < BypassDepth; i++) begin
                entryAddr[i] <= entryAddr[i-1];
                entryValue[i] <= entryValue[i-1];
            end
        end
    end

    // A valid write must name a known register
    writeAddrKnown: assert property (
        @(posedge clk) disable iff (!rstN)
        bus.writeEnable |-> !$isunknown(bus.writeAddr)
    ) else $error("bypassLogic: unknown writeAddr with writeEnable high");

endmodule

// ==== source/operandReadStage.sv ====
`timescale 1ns/1ps

module operandReadStage #(
    parameter int BypassDepth = 3
) (
    input  logic                clk,
    input  logic                rstN,
    input  logic                writeEnable,
    input  rafiPkg::regAddrT    writeAddr,
    input  rafiPkg::wordT       writeValue,
    input  rafiPkg::regAddrT    readAddr1,
    input  rafiPkg::regAddrT    readAddr2,
    input  logic                flushReq,
    input  logic                stallReq,
    input  rafiPkg::stallCountT stallCycles,
    output rafiPkg::wordT       operand1,
    output rafiPkg::wordT       operand2,
    output logic                hit1,
    output logic                hit2,
    output logic                stalled
);
    import rafiPkg::*;

    logic       flush;
    logic       bypassStall;
    logic       timerLoad;
    logic       timerDone;
    stallCountT timerCycles;

    bypassIf #(.BypassDepth(BypassDepth)) bus ();

    // Write-back port feeds the bypass pipeline directly
    assign bus.writeEnable = writeEnable;
    assign bus.writeAddr = writeAddr;
    assign bus.writeValue = writeValue;

    bypassLogic #(.BypassDepth(BypassDepth)) uBypass (
        .clk         (clk),
        .rstN        (rstN),
        .bus         (bus.BypassLogic),
        .flush       (flush),
        .bypassStall (bypassStall)
    );

    operandRegFile uRegFile (
        .clk         (clk),
        .rstN        (rstN),
        .bus         (bus.Reader),
        .bypassStall (bypassStall),
        .flush       (flush),
        .writeEnable (writeEnable),
        .writeAddr   (writeAddr),
        .writeValue  (writeValue),
        .readAddr1   (readAddr1),
        .readAddr2   (readAddr2),
        .operand1    (operand1),
        .operand2    (operand2),
        .hit1        (hit1),
        .hit2        (hit2)
    );

    stallTimer uTimer (
        .clk         (clk),
        .rstN        (rstN),
        .load        (timerLoad),
        .stallCycles (timerCycles),
        .done        (timerDone)
    );

    pipelineController uCtrl (
        .clk           (clk),
        .rstN          (rstN),
        .flushReq      (flushReq),
        .stallReq      (stallReq),
        .stallCyclesIn (stallCycles),
        .flush         (flush),
        .bypassStall   (bypassStall),
        .stalled       (stalled),
        .load          (timerLoad),
        .stallCycles   (timerCycles),
        .done          (timerDone)
    );

endmodule

// ==== source/operandRegFile.sv ====
`timescale 1ns/1ps

module operandRegFile (
    input  logic             clk,
    input  logic             rstN,
    bypassIf.Reader          bus,
    input  logic             bypassStall,
    input  logic             flush,
    input  logic             writeEnable,
    input  rafiPkg::regAddrT writeAddr,
    input  rafiPkg::wordT    writeValue,
    input  rafiPkg::regAddrT readAddr1,
    input  rafiPkg::regAddrT readAddr2,
    output rafiPkg::wordT    operand1,
    output rafiPkg::wordT    operand2,
    output logic             hit1,
    output logic             hit2
);
    import rafiPkg::*;

    // x0 has no storage
    wordT regs [1:RegCount-1];
    wordT regValue1;
    wordT regValue2;
    logic writeAccept;

    assign writeAccept = writeEnable && !bypassStall && !flush && (writeAddr != '0);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeAccept) begin
            regs[writeAddr] <= writeValue;
        end
    end

    assign regValue1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
    assign regValue2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

    // Same addresses look up the bypass CAM
    assign bus.readAddr1 = readAddr1;
    assign bus.readAddr2 = readAddr2;

    // Bypass result overrides the architectural value
    assign operand1 = bus.hit1 ? bus.readValue1 : regValue1;
    assign operand2 = bus.hit2 ? bus.readValue2 : regValue2;
    assign hit1 = bus.hit1;
    assign hit2 = bus.hit2;

endmodule

// ==== source/pipelineController.sv ====
`timescale 1ns/1ps

module pipelineController (
    input  logic                clk,
    input  logic                rstN,
    input  logic                flushReq,
    input  logic                stallReq,
    input  rafiPkg::stallCountT stallCyclesIn,
    output logic                flush,
    output logic                bypassStall,
    output logic                stalled,
    output logic                load,
    output rafiPkg::stallCountT stallCycles,
    input  logic                done
);
    import rafiPkg::*;

    ctrlStateT state;
    ctrlStateT nextState;

    // Requests only count in Run, flush beats stall
    always_comb begin
        nextState = state;
        case (state)
            Run: begin
                if (flushReq) begin
                    nextState = Flush;
                end else if (stallReq) begin
                    nextState = Stall;
                end
            end
            Stall: begin
                if (done) begin
                    nextState = Run;
                end
            end
            Flush: begin
                nextState = Run;
            end
            default: begin
                nextState = Run;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= Run;
        end else begin
            state <= nextState;
        end
    end

    assign flush = (state == Flush);
    assign bypassStall = (state == Stall);
    assign stalled = (state == Stall);

    // Timer gets N-1 so done shows up in the last stall cycle
    assign load = (state == Run) && stallReq && !flushReq;
    assign stallCycles = (stallCyclesIn == '0) ? '0 : stallCyclesIn - stallCountT'(1);

    // Timer rests at zero whenever the pipeline is not stalled
    timerIdleOutsideStall: assert property (
        @(posedge clk) disable iff (!rstN)
        !bypassStall |-> done
    ) else $error("pipelineController: stall timer running outside Stall");

endmodule

// ==== source/rafiPkg.sv ====
package rafiPkg;

    // Widths of the integer datapath
    localparam int WordWidth = 32;
    localparam int RegAddrWidth = 5;
    localparam int RegCount = 32;
    localparam int StallCountWidth = 8;

    // Architectural data word
    typedef logic [WordWidth-1:0] wordT;

    // Register index, x0 to x31
    typedef logic [RegAddrWidth-1:0] regAddrT;

    // Length of a requested stall in cycles
    typedef logic [StallCountWidth-1:0] stallCountT;

    // Pipeline controller states
    typedef enum logic [1:0] {
        Run   = 2'd0,
        Stall = 2'd1,
        Flush = 2'd2
    } ctrlStateT;

endpackage

// ==== source/stallTimer.sv ====
`timescale 1ns/1ps

module stallTimer (
    input  logic                clk,
    input  logic                rstN,
    input  logic                load,
    input  rafiPkg::stallCountT stallCycles,
    output logic                done
);
    import rafiPkg::*;

    stallCountT count;

    // Counts down to zero and rests there
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            count <= '0;
        end else if (load) begin
            count <= stallCycles;
        end else if (count != '0) begin
            count <= count - stallCountT'(1);
        end
    end

    assign done = (count == '0);

    // Controller only reloads an idle timer
    loadWhenIdle: assert property (
        @(posedge clk) disable iff (!rstN)
        load |-> (count == '0)
    ) else $error("stallTimer: load while count is %0d", count);

endmodule

// ==== verif/operandReadModel.svh ====
`ifndef OPERAND_READ_MODEL_SVH
`define OPERAND_READ_MODEL_SVH

// Architectural registers, and shifts since each address was last written
wordT        archRegs [32];
int unsigned regAge [32];
int          stallLeft;
bit          flushPending;
logic [31:0] lcgState = 32'h5eef_bfae;

function automatic void resetModel();
    for (int r = 0; r < 32; r++) begin
        archRegs[r] = '0;
        regAge[r] = BypassDepth;
    end
    stallLeft = 0;
    flushPending = 1'b0;
endfunction

function automatic wordT expectOperand(input regAddrT addr);
    return (addr == '0) ? '0 : archRegs[addr];
endfunction

// Still inside the bypass window and not flushed since
function automatic logic expectHit(input regAddrT addr);
    return regAge[addr] < BypassDepth;
endfunction

function automatic logic expectStalled();
    return stallLeft > 0;
endfunction

// One rising edge, with the inputs the DUT samples on it
function automatic void advanceModel(input logic we, input regAddrT wa, input wordT wv,
                                     input logic fReq, input logic sReq, input stallCountT n);
    if (stallLeft > 0) begin
        stallLeft--;
    end else if (flushPending) begin
        flushPending = 1'b0;
        for (int r = 0; r < 32; r++) begin
            regAge[r] = BypassDepth;
        end
    end else begin
        for (int r = 0; r < 32; r++) begin
            if (regAge[r] < BypassDepth) begin
                regAge[r]++;
            end
        end
        if (we) begin
            // x0 writes still occupy a bypass slot
            regAge[wa] = 0;
            if (wa != '0) begin
                archRegs[wa] = wv;
            end
        end
        if (fReq) begin
            flushPending = 1'b1;
        end else if (sReq) begin
            stallLeft = (n == '0) ? 1 : int'(n);
        end
    end
endfunction

function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
endfunction

`endif

// ==== verif/operandReadStageTb.sv ====
`timescale 1ns/1ps

module operandReadStageTb;
    import rafiPkg::*;

    localparam int BypassDepth = 3;
    localparam int ClockPeriod = 40;
    localparam int ResetCycles = 8;
    localparam int DirectedCycles = 60;
    localparam int RandomCycles = 400;
    localparam int TimeoutNs = (ResetCycles + DirectedCycles + RandomCycles) * ClockPeriod + 2000;

    logic       clk = 1'b0;
    logic       rstN;
    logic       writeEnable;
    regAddrT    writeAddr;
    wordT       writeValue;
    regAddrT    readAddr1;
    regAddrT    readAddr2;
    logic       flushReq;
    logic       stallReq;
    stallCountT stallCycles;
    wordT       operand1;
    wordT       operand2;
    logic       hit1;
    logic       hit2;
    logic       stalled;
    int         errorCount = 0;

    `include "operandReadModel.svh"

    operandReadStage #(.BypassDepth(BypassDepth)) dut (
        .clk         (clk),
        .rstN        (rstN),
        .writeEnable (writeEnable),
        .writeAddr   (writeAddr),
        .writeValue  (writeValue),
        .readAddr1   (readAddr1),
        .readAddr2   (readAddr2),
        .flushReq    (flushReq),
        .stallReq    (stallReq),
        .stallCycles (stallCycles),
        .operand1    (operand1),
        .operand2    (operand2),
        .hit1        (hit1),
        .hit2        (hit2),
        .stalled     (stalled)
    );

    always #(ClockPeriod / 2) clk = ~clk;

    // One cycle of stimulus, applied on the falling edge
    task automatic driveCycle(input logic we, input regAddrT wa, input wordT wv,
                              input regAddrT ra1, input regAddrT ra2,
                              input logic fReq, input logic sReq, input stallCountT n);
        @(negedge clk);
        writeEnable = we;
        writeAddr = wa;
        writeValue = wv;
        readAddr1 = ra1;
        readAddr2 = ra2;
        flushReq = fReq;
        stallReq = sReq;
        stallCycles = n;
    endtask

    task automatic idleReads(input regAddrT ra1, input regAddrT ra2, input int cycles);
        repeat (cycles) begin
            driveCycle(1'b0, '0, '0, ra1, ra2, 1'b0, 1'b0, '0);
        end
    endtask

    task automatic reportMismatch(input string what, input wordT got, input wordT want);
        errorCount++;
        $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, want);
    endtask

    // Compare in the middle of the low phase, then advance the model on the edge
    initial begin
        forever begin
            @(negedge clk);
            #(ClockPeriod / 4);
            if (rstN === 1'b1) begin
                if (operand1 !== expectOperand(readAddr1)) begin
                    reportMismatch("operand1", operand1, expectOperand(readAddr1));
                end
                if (operand2 !== expectOperand(readAddr2)) begin
                    reportMismatch("operand2", operand2, expectOperand(readAddr2));
                end
                if (hit1 !== expectHit(readAddr1)) begin
                    reportMismatch("hit1", wordT'(hit1), wordT'(expectHit(readAddr1)));
                end
                if (hit2 !== expectHit(readAddr2)) begin
                    reportMismatch("hit2", wordT'(hit2), wordT'(expectHit(readAddr2)));
                end
                if (stalled !== expectStalled()) begin
                    reportMismatch("stalled", wordT'(stalled), wordT'(expectStalled()));
                end
            end
            @(posedge clk);
            if (rstN === 1'b1) begin
                advanceModel(writeEnable, writeAddr, writeValue, flushReq, stallReq, stallCycles);
            end
        end
    end

    initial begin
        logic [31:0] ctrlBits;
        rstN = 1'b0;
        writeEnable = 1'b0;
        writeAddr = '0;
        writeValue = '0;
        readAddr1 = '0;
        readAddr2 = '0;
        flushReq = 1'b0;
        stallReq = 1'b0;
        stallCycles = '0;
        resetModel();
        repeat (ResetCycles) @(negedge clk);
        rstN = 1'b1;

        // Every register reads zero out of reset
        for (int a = 0; a < 32; a += 2) begin
            idleReads(regAddrT'(a), regAddrT'(a + 1), 1);
        end

        // Single write, watch the hit expire
        driveCycle(1'b1, 5'd5, 32'hcafe_0005, 5'd5, 5'd0, 1'b0, 1'b0, '0);
        idleReads(5'd5, 5'd0, BypassDepth + 2);

        // Back-to-back writes to one register
        driveCycle(1'b1, 5'd7, 32'h1111_0007, 5'd7, 5'd7, 1'b0, 1'b0, '0);
        driveCycle(1'b1, 5'd7, 32'h2222_0007, 5'd7, 5'd7, 1'b0, 1'b0, '0);
        driveCycle(1'b1, 5'd7, 32'h3333_0007, 5'd7, 5'd7, 1'b0, 1'b0, '0);
        idleReads(5'd7, 5'd7, BypassDepth + 1);

        // Four-cycle stall with writes offered that must be dropped
        driveCycle(1'b1, 5'd9, 32'h9999_0009, 5'd9, 5'd10, 1'b0, 1'b0, '0);
        driveCycle(1'b0, '0, '0, 5'd9, 5'd10, 1'b0, 1'b1, 8'd4);
        repeat (4) begin
            driveCycle(1'b1, 5'd10, 32'hdead_000a, 5'd9, 5'd10, 1'b0, 1'b0, '0);
        end
        idleReads(5'd9, 5'd10, BypassDepth + 1);

        // Flush drops the bypass entries but not the register file
        driveCycle(1'b1, 5'd12, 32'h1212_000c, 5'd12, 5'd5, 1'b0, 1'b0, '0);
        driveCycle(1'b0, '0, '0, 5'd12, 5'd5, 1'b1, 1'b0, '0);
        idleReads(5'd12, 5'd5, 3);

        // Random mix over a small address range so hits are frequent
        for (int c = 0; c < RandomCycles; c++) begin
            ctrlBits = nextRandom();
            driveCycle(ctrlBits[31], regAddrT'(ctrlBits[29:27]), nextRandom(),
                       regAddrT'(ctrlBits[26:24]), regAddrT'(ctrlBits[23:21]),
                       ctrlBits[20:16] == 5'd0, ctrlBits[15:13] == 3'd0,
                       stallCountT'(ctrlBits[12:10]) + stallCountT'(1));
        end
        idleReads(5'd0, 5'd0, 2);

        $display("Checks finished with %0d errors", errorCount);
        if (errorCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(TimeoutNs);
        $display("Watchdog expired, the run did not finish within %0d ns", TimeoutNs);
        $display("TB FAILED");
        $finish;
    end

endmodule
